// ==== source/issue_pkg.sv ====
package issue_pkg;

    // ------------------------------
    // widths and sizes
    // ------------------------------
    // integer data width
    localparam int unsigned XLEN            = 32;
    // write-back ports from commit
    localparam int unsigned NR_COMMIT_PORTS = 2;
    localparam int unsigned REG_ADDR_W      = 5;
    localparam int unsigned NR_REGS         = 32;
    // scoreboard transaction id
    localparam int unsigned TRANS_ID_W      = 3;
    // virtual address width of the pc
    localparam int unsigned VLEN            = 32;

    // ------------------------------
    // encodings
    // ------------------------------
    // functional unit needed by an instruction, or writing a register
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        MULT,
        LOAD,
        STORE,
        CSR
    } fu_t;

    // operation code, passed through to execute untouched
    typedef enum logic [5:0] {
        ADD, SUB, XORL, ORL, ANDL,
        SRA, SRL, SLL, SLTS, SLTU,
        EQ, NE, LTS, GES, LTU, GEU,
        JALR, BRANCH,
        LW, LH, LHU, LB, LBU, SW, SH, SB,
        MUL, MULH, MULHU, MULHSU, DIV, DIVU, REM, REMU,
        CSR_WRITE, CSR_READ, CSR_SET, CSR_CLEAR
    } fu_op_t;

    // ------------------------------
    // bundles
    // ------------------------------
    // decoded instruction as handed over by the scoreboard
    typedef struct packed {
        logic [VLEN-1:0]       pc;
        logic [TRANS_ID_W-1:0] trans_id;
        fu_t                   fu;
        fu_op_t                op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        // holds the immediate at issue time
        logic [XLEN-1:0]       result;
        logic                  use_imm;
        logic                  use_zimm;
        logic                  use_pc;
        // an exception was raised further up the pipe
        logic                  ex_valid;
        logic                  is_compressed;
    } issue_entry_t;

    // one register file write port
    typedef struct packed {
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        logic                  we;
    } commit_port_t;

    // operands and control going to execute
    typedef struct packed {
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       operand_b;
        logic [XLEN-1:0]       imm;
        fu_t                   fu;
        fu_op_t                op;
        logic [TRANS_ID_W-1:0] trans_id;
    } fu_data_t;

    // single cycle start strobes, one per unit
    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } fu_valid_t;

endpackage

// ==== source/int_regfile.sv ====
`timescale 1ns/10ps

module int_regfile #(
    parameter int unsigned XLEN            = issue_pkg::XLEN,
    parameter int unsigned NR_COMMIT_PORTS = issue_pkg::NR_COMMIT_PORTS
) (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    // read ports, one per source operand
    input  logic [issue_pkg::REG_ADDR_W-1:0]            raddr_a_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0]            raddr_b_i,
    output logic [XLEN-1:0]                             rdata_a_o,
    output logic [XLEN-1:0]                             rdata_b_o,
    // write ports from commit
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i
);
    import issue_pkg::*;

    // x0 has no storage, only x1..x31 are kept
    logic [NR_REGS-1:1][XLEN-1:0] regs_q;
    logic [NR_REGS-1:1][XLEN-1:0] regs_d;

    // ------------------------------
    // write side
    // ------------------------------
    // ports are walked in order so the highest enabled port
    // lands last on a shared address
    always_comb begin : write_merge
        regs_d = regs_q;
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            // writes to x0 are dropped
            if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                regs_d[commit_i[p].waddr] = commit_i[p].wdata;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : reg_array
        if (!rst_ni) begin
            regs_q <= '0;
        end else begin
            regs_q <= regs_d;
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    // combinational, x0 always reads as zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== source/hazard_check.sv ====
`timescale 1ns/10ps

module hazard_check #(
    parameter int unsigned NR_COMMIT_PORTS = issue_pkg::NR_COMMIT_PORTS
) (
    // instruction from the scoreboard
    input  issue_pkg::issue_entry_t                       issue_instr_i,
    input  logic                                          issue_valid_i,
    // pending writer of every register
    input  issue_pkg::fu_t [issue_pkg::NR_REGS-1:0]       rd_clobber_i,
    // scoreboard has the source value ready
    input  logic                                          rs1_valid_i,
    input  logic                                          rs2_valid_i,
    // unit ready levels
    input  logic                                          flu_ready_i,
    input  logic                                          lsu_ready_i,
    // commit writes of this cycle
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    // mult strobe raised last cycle
    input  logic                                          mult_pending_i,
    // scoreboard lookup addresses
    output logic [issue_pkg::REG_ADDR_W-1:0]              rs1_o,
    output logic [issue_pkg::REG_ADDR_W-1:0]              rs2_o,
    output logic                                          forward_a_o,
    output logic                                          forward_b_o,
    output logic                                          issue_ack_o
);
    import issue_pkg::*;

    fu_t  rs1_clobber;
    fu_t  rs2_clobber;
    fu_t  rd_clobber;
    logic stall;
    logic fu_busy;
    logic rd_free;

    // scoreboard is polled with the raw source fields
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    assign rs1_clobber = rd_clobber_i[issue_instr_i.rs1];
    assign rs2_clobber = rd_clobber_i[issue_instr_i.rs2];
    assign rd_clobber  = rd_clobber_i[issue_instr_i.rd];

    // ------------------------------
    // source operands
    // ------------------------------
    // a clobbered source is taken from the scoreboard if it is there,
    // csr results only ever come through the register file
    always_comb begin : source_check
        stall       = 1'b0;
        forward_a_o = 1'b0;
        forward_b_o = 1'b0;
        // zimm uses the rs1 field as an immediate, nothing to wait for
        if (!issue_instr_i.use_zimm && (rs1_clobber != NONE)) begin
            if (rs1_valid_i && (rs1_clobber != CSR)) begin
                forward_a_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rs2_clobber != NONE) begin
            if (rs2_valid_i && (rs2_clobber != CSR)) begin
                forward_b_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // busy level of the unit the instruction needs
    always_comb begin : unit_busy
        case (issue_instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // ------------------------------
    // write after write
    // ------------------------------
    // rd is free if nobody holds it, or it retires right now
    always_comb begin : waw_check
        rd_free = (rd_clobber == NONE);
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
                rd_free = 1'b1;
            end
        end
    end

    // ------------------------------
    // acknowledge
    // ------------------------------
    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // excepted or unit-less instructions just leave the queue
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // the mult result shares the fixed latency bus, only
        // another mult can follow directly
        if (mult_pending_i && (issue_instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

// ==== source/operand_dispatch.sv ====
`timescale 1ns/10ps

module operand_dispatch #(
    parameter int unsigned XLEN = issue_pkg::XLEN
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    // instruction and its handshake
    input  issue_pkg::issue_entry_t       issue_instr_i,
    input  logic                          issue_valid_i,
    input  logic                          issue_ack_i,
    // forwarding decision from the hazard logic
    input  logic                          forward_a_i,
    input  logic                          forward_b_i,
    // scoreboard values
    input  logic [XLEN-1:0]               rs1_i,
    input  logic [XLEN-1:0]               rs2_i,
    // register file values
    input  logic [XLEN-1:0]               rdata_a_i,
    input  logic [XLEN-1:0]               rdata_b_i,
    // to execute
    output issue_pkg::fu_data_t           fu_data_o,
    output issue_pkg::fu_valid_t          fu_valid_o,
    output logic [issue_pkg::VLEN-1:0]    pc_o,
    output logic                          is_compressed_o,
    // mult went out last cycle
    output logic                          mult_pending_o
);
    import issue_pkg::*;

    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic            imm_allowed;
    fu_data_t        fu_data_d;
    fu_data_t        fu_data_q;
    fu_valid_t       fu_valid_d;
    fu_valid_t       fu_valid_q;

    // ------------------------------
    // operand select
    // ------------------------------
    // stores and branches keep rs2, their immediate goes via imm
    assign imm_allowed = issue_instr_i.use_imm
                         && (issue_instr_i.fu != STORE)
                         && (issue_instr_i.fu != CTRL_FLOW);

    // later assignments take priority
    always_comb begin : operand_mux
        operand_a = rdata_a_i;
        operand_b = rdata_b_i;
        if (forward_a_i) begin
            operand_a = rs1_i;
        end
        if (forward_b_i) begin
            operand_b = rs2_i;
        end
        // auipc and jumps, pc sign extended
        if (issue_instr_i.use_pc) begin
            operand_a = XLEN'(signed'(issue_instr_i.pc));
        end
        // csr immediate, zero extended
        if (issue_instr_i.use_zimm) begin
            operand_a = XLEN'(issue_instr_i.rs1);
        end
        if (imm_allowed) begin
            operand_b = issue_instr_i.result;
        end
    end

    always_comb begin : payload_next
        fu_data_d.operand_a = operand_a;
        fu_data_d.operand_b = operand_b;
        fu_data_d.imm       = issue_instr_i.result;
        fu_data_d.fu        = issue_instr_i.fu;
        fu_data_d.op        = issue_instr_i.op;
        fu_data_d.trans_id  = issue_instr_i.trans_id;
    end

    // ------------------------------
    // unit strobes
    // ------------------------------
    always_comb begin : strobe_next
        fu_valid_d = '0;
        if (issue_valid_i && issue_ack_i && !issue_instr_i.ex_valid) begin
            case (issue_instr_i.fu)
                ALU:         fu_valid_d.alu    = 1'b1;
                CTRL_FLOW:   fu_valid_d.branch = 1'b1;
                MULT:        fu_valid_d.mult   = 1'b1;
                LOAD, STORE: fu_valid_d.lsu    = 1'b1;
                CSR:         fu_valid_d.csr    = 1'b1;
                default:     fu_valid_d        = '0;
            endcase
        end
        // a flush must not start a unit on stale operands
        if (flush_i) begin
            fu_valid_d = '0;
        end
    end

    // ------------------------------
    // id/ex register
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : id_ex_reg
        if (!rst_ni) begin
            fu_data_q       <= '{operand_a: '0, operand_b: '0, imm: '0,
                                 fu: NONE, op: ADD, trans_id: '0};
            fu_valid_q      <= '0;
            pc_o            <= '0;
            is_compressed_o <= 1'b0;
        end else begin
            // payload loads every cycle, only the strobes qualify it
            fu_data_q       <= fu_data_d;
            fu_valid_q      <= fu_valid_d;
            pc_o            <= issue_instr_i.pc;
            is_compressed_o <= issue_instr_i.is_compressed;
        end
    end

    assign fu_data_o      = fu_data_q;
    assign fu_valid_o     = fu_valid_q;
    assign mult_pending_o = fu_valid_q.mult;

endmodule

// ==== source/issue_read_operands.sv ====
`timescale 1ns/10ps

module issue_read_operands #(
    parameter int unsigned XLEN            = issue_pkg::XLEN,
    parameter int unsigned NR_COMMIT_PORTS = issue_pkg::NR_COMMIT_PORTS
) (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic                                          flush_i,
    // from the scoreboard
    input  issue_pkg::issue_entry_t                       issue_instr_i,
    input  logic                                          issue_valid_i,
    output logic                                          issue_ack_o,
    // source lookup in the scoreboard
    output logic [issue_pkg::REG_ADDR_W-1:0]              rs1_o,
    input  logic [XLEN-1:0]                               rs1_i,
    input  logic                                          rs1_valid_i,
    output logic [issue_pkg::REG_ADDR_W-1:0]              rs2_o,
    input  logic [XLEN-1:0]                               rs2_i,
    input  logic                                          rs2_valid_i,
    input  issue_pkg::fu_t [issue_pkg::NR_REGS-1:0]       rd_clobber_i,
    // write back
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    // fixed latency units and load/store unit
    input  logic                                          flu_ready_i,
    input  logic                                          lsu_ready_i,
    // to execute
    output issue_pkg::fu_data_t                           fu_data_o,
    output issue_pkg::fu_valid_t                          fu_valid_o,
    output logic [issue_pkg::VLEN-1:0]                    pc_o,
    output logic                                          is_compressed_o
);

    logic            forward_a;
    logic            forward_b;
    logic            mult_pending;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;

    // ------------------------------
    // operand sources
    // ------------------------------
    int_regfile #(
        .XLEN            ( XLEN            ),
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_int_regfile (
        .clk_i     ( clk_i             ),
        .rst_ni    ( rst_ni            ),
        .raddr_a_i ( issue_instr_i.rs1 ),
        .raddr_b_i ( issue_instr_i.rs2 ),
        .rdata_a_o ( rdata_a           ),
        .rdata_b_o ( rdata_b           ),
        .commit_i  ( commit_i          )
    );

    // hazards and issue decision
    hazard_check #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_hazard_check (
        .issue_instr_i  ( issue_instr_i ),
        .issue_valid_i  ( issue_valid_i ),
        .rd_clobber_i   ( rd_clobber_i  ),
        .rs1_valid_i    ( rs1_valid_i   ),
        .rs2_valid_i    ( rs2_valid_i   ),
        .flu_ready_i    ( flu_ready_i   ),
        .lsu_ready_i    ( lsu_ready_i   ),
        .commit_i       ( commit_i      ),
        .mult_pending_i ( mult_pending  ),
        .rs1_o          ( rs1_o         ),
        .rs2_o          ( rs2_o         ),
        .forward_a_o    ( forward_a     ),
        .forward_b_o    ( forward_b     ),
        .issue_ack_o    ( issue_ack_o   )
    );

    // ------------------------------
    // dispatch
    // ------------------------------
    operand_dispatch #(
        .XLEN ( XLEN )
    ) i_operand_dispatch (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .flush_i         ( flush_i         ),
        .issue_instr_i   ( issue_instr_i   ),
        .issue_valid_i   ( issue_valid_i   ),
        .issue_ack_i     ( issue_ack_o     ),
        .forward_a_i     ( forward_a       ),
        .forward_b_i     ( forward_b       ),
        .rs1_i           ( rs1_i           ),
        .rs2_i           ( rs2_i           ),
        .rdata_a_i       ( rdata_a         ),
        .rdata_b_i       ( rdata_b         ),
        .fu_data_o       ( fu_data_o       ),
        .fu_valid_o      ( fu_valid_o      ),
        .pc_o            ( pc_o            ),
        .is_compressed_o ( is_compressed_o ),
        .mult_pending_o  ( mult_pending    )
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS    = 100,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_no
);

    // free running clock, 50 percent duty
    initial begin : clock
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // reset low from time zero, released on a rising edge
    initial begin : reset
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

// ==== tb/tb_issue_read_operands.sv ====
`timescale 1ns/10ps

module tb_issue_read_operands;
    import issue_pkg::*;

    localparam int unsigned RESET_CYCLES   = 16;
    localparam int unsigned NUM_CYCLES     = 3000;
    localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + NUM_CYCLES + 100;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 flush;
    issue_entry_t                         issue_instr;
    logic                                 issue_valid;
    logic                                 issue_ack;
    logic [REG_ADDR_W-1:0]                rs1_addr;
    logic [REG_ADDR_W-1:0]                rs2_addr;
    logic [XLEN-1:0]                      rs1_data;
    logic [XLEN-1:0]                      rs2_data;
    logic                                 rs1_valid;
    logic                                 rs2_valid;
    fu_t [NR_REGS-1:0]                    rd_clobber;
    commit_port_t [NR_COMMIT_PORTS-1:0]   commit;
    logic                                 flu_ready;
    logic                                 lsu_ready;
    fu_data_t                             fu_data;
    fu_valid_t                            fu_valid;
    logic [VLEN-1:0]                      pc;
    logic                                 is_compressed;

    // reference model state
    logic [XLEN-1:0] mirror [NR_REGS];
    fu_data_t        exp_data;
    fu_valid_t       exp_valid;
    logic [VLEN-1:0] exp_pc;
    logic            exp_comp;
    // scoreboard keeps the entry until it is taken
    logic            hold;
    logic [31:0]     lfsr_state;
    int unsigned     cycle_cnt = 0;
    int unsigned     n_dispatched = 0;
    int unsigned     n_waiting = 0;

    tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) i_clk_gen (
        .clk_o  ( clk   ),
        .rst_no ( rst_n )
    );

    issue_read_operands #(.XLEN(XLEN), .NR_COMMIT_PORTS(NR_COMMIT_PORTS)) UUT (
        .clk_i           ( clk           ),
        .rst_ni          ( rst_n         ),
        .flush_i         ( flush         ),
        .issue_instr_i   ( issue_instr   ),
        .issue_valid_i   ( issue_valid   ),
        .issue_ack_o     ( issue_ack     ),
        .rs1_o           ( rs1_addr      ),
        .rs1_i           ( rs1_data      ),
        .rs1_valid_i     ( rs1_valid     ),
        .rs2_o           ( rs2_addr      ),
        .rs2_i           ( rs2_data      ),
        .rs2_valid_i     ( rs2_valid     ),
        .rd_clobber_i    ( rd_clobber    ),
        .commit_i        ( commit        ),
        .flu_ready_i     ( flu_ready     ),
        .lsu_ready_i     ( lsu_ready     ),
        .fu_data_o       ( fu_data       ),
        .fu_valid_o      ( fu_valid      ),
        .pc_o            ( pc            ),
        .is_compressed_o ( is_compressed )
    );

    // ------------------------------
    // random source
    // ------------------------------
    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // unused code 7 becomes an extra chance for mult
    function automatic fu_t rand_fu();
        logic [2:0] r;
        r = 3'(rand_bits(3));
        if (r == 3'd7) begin
            return MULT;
        end
        return fu_t'(r);
    endfunction

    task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic drive_inputs();
        issue_entry_t                       instr;
        fu_t [NR_REGS-1:0]                  clob;
        commit_port_t [NR_COMMIT_PORTS-1:0] cmt;
        instr = issue_instr;
        if (!hold) begin
            instr.pc            = VLEN'(rand_bits(VLEN));
            instr.trans_id      = TRANS_ID_W'(rand_bits(TRANS_ID_W));
            instr.fu            = rand_fu();
            instr.op            = fu_op_t'(6'(rand_bits(5)));
            instr.rs1           = REG_ADDR_W'(rand_bits(REG_ADDR_W));
            instr.rs2           = REG_ADDR_W'(rand_bits(REG_ADDR_W));
            instr.rd            = REG_ADDR_W'(rand_bits(REG_ADDR_W));
            instr.result        = XLEN'(rand_bits(XLEN));
            instr.use_imm       = 1'(rand_bits(1));
            instr.use_zimm      = (rand_bits(2) == 0);
            instr.use_pc        = (rand_bits(2) == 0);
            instr.ex_valid      = (rand_bits(3) == 0);
            instr.is_compressed = 1'(rand_bits(1));
        end
        // mostly unclobbered so that plenty of instructions go out
        for (int unsigned r = 0; r < NR_REGS; r++) begin
            clob[r] = (rand_bits(2) != 0) ? NONE : rand_fu();
        end
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            cmt[p].we    = 1'(rand_bits(1));
            cmt[p].waddr = REG_ADDR_W'(rand_bits(REG_ADDR_W));
            cmt[p].wdata = XLEN'(rand_bits(XLEN));
        end
        issue_instr <= instr;
        issue_valid <= hold || (rand_bits(3) != 0);
        rd_clobber  <= clob;
        commit      <= cmt;
        rs1_data    <= XLEN'(rand_bits(XLEN));
        rs2_data    <= XLEN'(rand_bits(XLEN));
        rs1_valid   <= (rand_bits(2) != 0);
        rs2_valid   <= (rand_bits(2) != 0);
        flu_ready   <= (rand_bits(3) != 0);
        lsu_ready   <= (rand_bits(3) != 0);
        flush       <= (rand_bits(4) == 0);
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    // registered outputs against what the last edge should have loaded
    task automatic check_outputs();
        check_equal(fu_valid, exp_valid, "fu_valid_o");
        check_equal(fu_data, exp_data, "fu_data_o");
        check_equal(pc, exp_pc, "pc_o");
        check_equal(is_compressed, exp_comp, "is_compressed_o");
    endtask

    task automatic check_cycle();
        fu_t       c1;
        fu_t       c2;
        fu_t       cd;
        logic      fwd_a;
        logic      fwd_b;
        logic      stall;
        logic      busy;
        logic      rd_free;
        logic      ack;
        fu_data_t  nxt;
        fu_valid_t vld;
        check_outputs();
        check_equal(rs1_addr, issue_instr.rs1, "rs1_o");
        check_equal(rs2_addr, issue_instr.rs2, "rs2_o");
        c1 = rd_clobber[issue_instr.rs1];
        c2 = rd_clobber[issue_instr.rs2];
        cd = rd_clobber[issue_instr.rd];
        // a zimm rs1 field is no register so it never waits
        fwd_a = !issue_instr.use_zimm && (c1 != NONE) && rs1_valid && (c1 != CSR);
        fwd_b = (c2 != NONE) && rs2_valid && (c2 != CSR);
        stall = (!issue_instr.use_zimm && (c1 != NONE) && !fwd_a) || ((c2 != NONE) && !fwd_b);
        case (issue_instr.fu)
            LOAD, STORE: busy = !lsu_ready;
            NONE:        busy = 1'b0;
            default:     busy = !flu_ready;
        endcase
        rd_free = (cd == NONE);
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit[p].we && (commit[p].waddr == issue_instr.rd)) begin
                rd_free = 1'b1;
            end
        end
        // exp_valid.mult still holds the strobe of the last cycle
        ack = issue_valid
              && ((!stall && !busy && rd_free) || issue_instr.ex_valid || (issue_instr.fu == NONE))
              && !(exp_valid.mult && (issue_instr.fu != MULT));
        check_equal(issue_ack, ack, "issue_ack_o");

        // operand a from lowest to highest priority
        nxt.operand_a = mirror[issue_instr.rs1];
        if (fwd_a) begin
            nxt.operand_a = rs1_data;
        end
        if (issue_instr.use_pc) begin
            nxt.operand_a = XLEN'($signed(issue_instr.pc));
        end
        if (issue_instr.use_zimm) begin
            nxt.operand_a = XLEN'(issue_instr.rs1);
        end
        nxt.operand_b = fwd_b ? rs2_data : mirror[issue_instr.rs2];
        if (issue_instr.use_imm && (issue_instr.fu != STORE) && (issue_instr.fu != CTRL_FLOW)) begin
            nxt.operand_b = issue_instr.result;
        end
        nxt.imm      = issue_instr.result;
        nxt.fu       = issue_instr.fu;
        nxt.op       = issue_instr.op;
        nxt.trans_id = issue_instr.trans_id;

        vld = '0;
        if (issue_valid && ack && !issue_instr.ex_valid && !flush) begin
            vld.alu    = (issue_instr.fu == ALU);
            vld.branch = (issue_instr.fu == CTRL_FLOW);
            vld.lsu    = (issue_instr.fu == LOAD) || (issue_instr.fu == STORE);
            vld.mult   = (issue_instr.fu == MULT);
            vld.csr    = (issue_instr.fu == CSR);
        end
        exp_data  = nxt;
        exp_valid = vld;
        exp_pc    = issue_instr.pc;
        exp_comp  = issue_instr.is_compressed;

        // commits land at the coming edge and the later port wins
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit[p].we && (commit[p].waddr != 0)) begin
                mirror[commit[p].waddr] = commit[p].wdata;
            end
        end
        hold = issue_valid && !ack;
        n_dispatched += (vld != '0);
        n_waiting    += hold;
    endtask

    // ------------------------------
    // run control
    // ------------------------------
    always @(posedge clk) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Regression failed");
            $fatal(1, "run timed out after %0d cycles", cycle_cnt);
        end
    end

    initial begin : stimulus
        lfsr_state  = 32'h04d823b0;
        hold        = 1'b0;
        flush       = 1'b0;
        issue_instr = '0;
        issue_valid = 1'b0;
        rs1_data    = '0;
        rs2_data    = '0;
        rs1_valid   = 1'b0;
        rs2_valid   = 1'b0;
        commit      = '0;
        flu_ready   = 1'b0;
        lsu_ready   = 1'b0;
        for (int unsigned r = 0; r < NR_REGS; r++) begin
            rd_clobber[r] = NONE;
            mirror[r]     = '0;
        end
        // reset image of the id/ex register
        exp_data  = '{operand_a: '0, operand_b: '0, imm: '0, fu: NONE, op: ADD, trans_id: '0};
        exp_valid = '0;
        exp_pc    = '0;
        exp_comp  = 1'b0;
        // first falling edge after a full clock high phase inside reset
        @(posedge clk);
        @(negedge clk);
        check_outputs();
        wait (rst_n === 1'b1);
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            check_cycle();
        end
        // payload of the last cycle
        @(negedge clk);
        check_outputs();
        $display("dispatched %0d, waited %0d cycles", n_dispatched, n_waiting);
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== src.f ====
source/issue_pkg.sv
source/int_regfile.sv
source/hazard_check.sv
source/operand_dispatch.sv
source/issue_read_operands.sv
tb/tb_clk_gen.sv
tb/tb_issue_read_operands.sv

// ==== Bender.yml ====
package:
  name: issue_read_operands

sources:
  - source/issue_pkg.sv
  - source/int_regfile.sv
  - source/hazard_check.sv
  - source/operand_dispatch.sv
  - source/issue_read_operands.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_issue_read_operands.sv
